// ==== logic/xt_chipset_macros.svh ====
//////////////////////////////
// Bus widths, on-board I/O port
// bases and the I/O wait state count
//////////////////////////////
`ifndef XT_CHIPSET_MACROS_SVH
`define XT_CHIPSET_MACROS_SVH

// Bus widths
`define XT_ADDR_WIDTH       20
`define XT_DATA_WIDTH       8

// Low address bits seen by the on-board port decode
`define XT_IO_DECODE_WIDTH  10

// Extra t3 cycles for I/O and interrupt acknowledge
`define XT_IO_WAIT_STATES   1

// Port block bases of 32 ports each
`define XT_PORT_DMA         10'h000
`define XT_PORT_PIC         10'h020
`define XT_PORT_PIT         10'h040
`define XT_PORT_PPI         10'h060
`define XT_PORT_PAGE        10'h080

`endif

// ==== logic/xt_chipset_pkg.sv ====
//////////////////////////////
// Status and state enums,
// command and select structs
//////////////////////////////
package xt_chipset_pkg;

    // Processor status code S2..S0
    typedef enum logic [2:0]
    {
        int_ack    = 3'd0,
        io_read    = 3'd1,
        io_write   = 3'd2,
        halt       = 3'd3,
        code_fetch = 3'd4,
        mem_read   = 3'd5,
        mem_write  = 3'd6,
        passive    = 3'd7
    } bus_status_e;

    // Bus cycle states
    typedef enum logic [2:0]
    {
        idle,
        t1,
        t2,
        t3,
        t4
    } bus_state_e;

    // Command strobes, all active low
    typedef struct packed
    {
        logic io_read_n;
        logic io_write_n;
        logic memory_read_n;
        logic memory_write_n;
        logic interrupt_acknowledge_n;
    } bus_command_t;

    // On-board device selects, active high
    typedef struct packed
    {
        logic dma;
        logic pic;
        logic pit;
        logic ppi;
        logic page;
    } device_select_t;

endpackage

// ==== logic/bus_cycle_control.sv ====
//////////////////////////////
// Bus cycle FSM: address latch
// pulse, command strobes, ready
//////////////////////////////
`timescale 1ns/1ns
`include "xt_chipset_macros.svh"

module bus_cycle_control (
    input  logic                         clock,
    input  logic                         reset,
    input  xt_chipset_pkg::bus_status_e  processor_status,
    input  logic                         io_channel_ready,
    output logic                         address_latch_enable,
    output logic                         processor_ready,
    output xt_chipset_pkg::bus_command_t command,
    output logic                         read_capture
);

    localparam int wait_width = (`XT_IO_WAIT_STATES > 0) ?
                                $clog2(`XT_IO_WAIT_STATES + 1) : 1;
    localparam logic [wait_width-1:0] wait_load = wait_width'(`XT_IO_WAIT_STATES);

    xt_chipset_pkg::bus_state_e  state;
    xt_chipset_pkg::bus_state_e  next_state;
    xt_chipset_pkg::bus_status_e status_q;
    logic [wait_width-1:0]       wait_count;
    logic                        cycle_start;
    logic                        io_cycle;
    logic                        t3_done;
    logic                        command_active;

    // Halt and passive never open a cycle
    assign cycle_start = (processor_status != xt_chipset_pkg::passive) &&
                         (processor_status != xt_chipset_pkg::halt);

    assign io_cycle = status_q inside {xt_chipset_pkg::int_ack,
                                       xt_chipset_pkg::io_read,
                                       xt_chipset_pkg::io_write};

    // Wait count only runs down while the channel is ready
    assign t3_done = io_channel_ready && (wait_count == '0);

    always_comb
    begin
        next_state = state;
        case (state)
            xt_chipset_pkg::idle:
            begin
                if (cycle_start)
                    next_state = xt_chipset_pkg::t1;
            end
            xt_chipset_pkg::t1:
                next_state = xt_chipset_pkg::t2;
            xt_chipset_pkg::t2:
                next_state = xt_chipset_pkg::t3;
            xt_chipset_pkg::t3:
            begin
                if (t3_done)
                    next_state = xt_chipset_pkg::t4;
            end
            default:
                next_state = xt_chipset_pkg::idle;
        endcase
    end

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            state <= xt_chipset_pkg::idle;
        else
            state <= next_state;
    end

    // Status is held from t1 to the end of t4
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            status_q <= xt_chipset_pkg::passive;
        else if ((state == xt_chipset_pkg::idle) && cycle_start)
            status_q <= processor_status;
    end

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            wait_count <= '0;
        else if (state == xt_chipset_pkg::t2)
            wait_count <= io_cycle ? wait_load : '0;
        else if ((state == xt_chipset_pkg::t3) && io_channel_ready && (wait_count != '0))
            wait_count <= wait_count - 1'b1;
    end

    assign address_latch_enable = (state == xt_chipset_pkg::t1);
    assign processor_ready      = (state == xt_chipset_pkg::t4);
    assign read_capture         = (state == xt_chipset_pkg::t3) && t3_done;
    assign command_active       = (state == xt_chipset_pkg::t2) ||
                                  (state == xt_chipset_pkg::t3);

    // One strobe per status, low from t2 through t3
    always_comb
    begin
        command = '1;
        if (command_active)
        begin
            case (status_q)
                xt_chipset_pkg::int_ack:
                    command.interrupt_acknowledge_n = 1'b0;
                xt_chipset_pkg::io_read:
                    command.io_read_n = 1'b0;
                xt_chipset_pkg::io_write:
                    command.io_write_n = 1'b0;
                xt_chipset_pkg::code_fetch,
                xt_chipset_pkg::mem_read:
                    command.memory_read_n = 1'b0;
                xt_chipset_pkg::mem_write:
                    command.memory_write_n = 1'b0;
                default:
                    command = '1;
            endcase
        end
    end

endmodule

// ==== logic/io_port_decode.sv ====
//////////////////////////////
// Address latch and on-board
// I/O device select decode
//////////////////////////////
`timescale 1ns/1ns
`include "xt_chipset_macros.svh"

module io_port_decode (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [`XT_ADDR_WIDTH-1:0]      cpu_address,
    input  logic                           address_latch_enable,
    input  xt_chipset_pkg::bus_command_t   command,
    output logic [`XT_ADDR_WIDTH-1:0]      address,
    output xt_chipset_pkg::device_select_t select
);

    // 32 ports per block
    localparam int block_low = 5;

    logic io_command;
    logic io_seen;
    logic io_active;
    logic on_board;
    logic [`XT_IO_DECODE_WIDTH-1:block_low] block;

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            address <= '0;
        else if (address_latch_enable)
            address <= cpu_address;
    end

    assign io_command = ~command.io_read_n | ~command.io_write_n;

    // Keeps the selects up after the strobe until the next latch pulse
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            io_seen <= 1'b0;
        else if (address_latch_enable)
            io_seen <= 1'b0;
        else if (io_command)
            io_seen <= 1'b1;
    end

    assign io_active = io_command | io_seen;
    assign on_board  = (address[`XT_ADDR_WIDTH-1:`XT_IO_DECODE_WIDTH] == '0);
    assign block     = address[`XT_IO_DECODE_WIDTH-1:block_low];

    always_comb
    begin
        select = '0;
        if (io_active && on_board)
        begin
            select.dma  = (block == `XT_PORT_DMA  >> block_low);
            select.pic  = (block == `XT_PORT_PIC  >> block_low);
            select.pit  = (block == `XT_PORT_PIT  >> block_low);
            select.ppi  = (block == `XT_PORT_PPI  >> block_low);
            select.page = (block == `XT_PORT_PAGE >> block_low);
        end
    end

endmodule

// ==== logic/refresh_request.sv ====
//////////////////////////////
// Refresh request on DMA
// channel 0, request vector
//////////////////////////////
`timescale 1ns/1ns

module refresh_request (
    input  logic       clock,
    input  logic       reset,
    input  logic       timer_out1,
    input  logic [3:0] dma_request,
    input  logic [3:0] dma_acknowledge_n,
    output logic [3:0] dma_request_out
);

    logic prev_timer;
    logic refresh_pending;

    // Starts high so a timer already high at reset is no edge
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            prev_timer <= 1'b1;
        else
            prev_timer <= timer_out1;
    end

    // Acknowledge has priority over a new edge
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            refresh_pending <= 1'b0;
        else if (~dma_acknowledge_n[0])
            refresh_pending <= 1'b0;
        else if (~prev_timer & timer_out1)
            refresh_pending <= 1'b1;
    end

    assign dma_request_out = {dma_request[3:1], refresh_pending};

endmodule

// ==== logic/data_bus_steer.sv ====
//////////////////////////////
// Read data source, bus
// direction and read data hold
//////////////////////////////
`timescale 1ns/1ns
`include "xt_chipset_macros.svh"

module data_bus_steer (
    input  logic                           clock,
    input  logic                           reset,
    input  xt_chipset_pkg::bus_command_t   command,
    input  xt_chipset_pkg::device_select_t select,
    input  logic                           read_capture,
    input  logic [`XT_DATA_WIDTH-1:0]      device_read_data,
    input  logic [`XT_DATA_WIDTH-1:0]      data_bus_ext,
    output logic [`XT_DATA_WIDTH-1:0]      cpu_read_data,
    output logic                           data_bus_direction
);

    logic                      io_read;
    logic                      internal_read;
    logic                      external_read;
    logic [`XT_DATA_WIDTH-1:0] read_source;

    assign io_read       = ~command.io_read_n;
    assign internal_read = io_read && (|select);
    assign external_read = (io_read && !(|select)) ||
                           ~command.memory_read_n ||
                           ~command.interrupt_acknowledge_n;

    always_comb
    begin
        read_source        = '0;
        data_bus_direction = 1'b0;
        if (internal_read)
            read_source = device_read_data;
        else if (external_read)
        begin
            read_source        = data_bus_ext;
            data_bus_direction = 1'b1;
        end
    end

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            cpu_read_data <= '0;
        else if (read_capture && (internal_read || external_read))
            cpu_read_data <= read_source;
    end

endmodule

// ==== logic/xt_chipset.sv ====
//////////////////////////////
// Chipset bus glue top level
//////////////////////////////
`timescale 1ns/1ns
`include "xt_chipset_macros.svh"

module xt_chipset (
    input  logic                           clock,
    input  logic                           reset,
    // Processor side
    input  logic [`XT_ADDR_WIDTH-1:0]      cpu_address,
    input  xt_chipset_pkg::bus_status_e    processor_status,
    output logic                           processor_ready,
    output logic [`XT_DATA_WIDTH-1:0]      cpu_read_data,
    // Channel side
    input  logic                           io_channel_ready,
    input  logic [`XT_DATA_WIDTH-1:0]      data_bus_ext,
    output logic [`XT_ADDR_WIDTH-1:0]      address,
    output logic                           address_latch_enable,
    output xt_chipset_pkg::bus_command_t   command,
    output logic                           data_bus_direction,
    // On-board devices
    input  logic                           timer_out1,
    input  logic [3:0]                     dma_request,
    input  logic [3:0]                     dma_acknowledge_n,
    input  logic [`XT_DATA_WIDTH-1:0]      device_read_data,
    output xt_chipset_pkg::device_select_t select,
    output logic [3:0]                     dma_request_out
);

    logic read_capture;

    bus_cycle_control i_bus_cycle_control (
        .clock                (clock),
        .reset                (reset),
        .processor_status     (processor_status),
        .io_channel_ready     (io_channel_ready),
        .address_latch_enable (address_latch_enable),
        .processor_ready      (processor_ready),
        .command              (command),
        .read_capture         (read_capture)
    );

    io_port_decode i_io_port_decode (
        .clock                (clock),
        .reset                (reset),
        .cpu_address          (cpu_address),
        .address_latch_enable (address_latch_enable),
        .command              (command),
        .address              (address),
        .select               (select)
    );

    data_bus_steer i_data_bus_steer (
        .clock                (clock),
        .reset                (reset),
        .command              (command),
        .select               (select),
        .read_capture         (read_capture),
        .device_read_data     (device_read_data),
        .data_bus_ext         (data_bus_ext),
        .cpu_read_data        (cpu_read_data),
        .data_bus_direction   (data_bus_direction)
    );

    refresh_request i_refresh_request (
        .clock                (clock),
        .reset                (reset),
        .timer_out1           (timer_out1),
        .dma_request          (dma_request),
        .dma_acknowledge_n    (dma_acknowledge_n),
        .dma_request_out      (dma_request_out)
    );

endmodule

// ==== verification/xt_chipset_checker.sv ====
//////////////////////////////
// Bus cycle and refresh request
// checker with error count
//////////////////////////////
`timescale 1ns/1ns
`include "xt_chipset_macros.svh"

module xt_chipset_checker (
    input  logic                           clock,
    input  logic                           reset,
    // Expected values from the testbench
    input  logic                           expect_cycle,
    input  xt_chipset_pkg::bus_command_t   expected_command,
    input  xt_chipset_pkg::device_select_t expected_select,
    input  logic [`XT_ADDR_WIDTH-1:0]      expected_address,
    input  logic                           expected_direction,
    input  logic [7:0]                     expected_length,
    input  logic [`XT_DATA_WIDTH-1:0]      expected_read_data,
    // DUT ports
    input  logic [`XT_ADDR_WIDTH-1:0]      address,
    input  logic                           address_latch_enable,
    input  xt_chipset_pkg::bus_command_t   command,
    input  xt_chipset_pkg::device_select_t select,
    input  logic                           processor_ready,
    input  logic [`XT_DATA_WIDTH-1:0]      cpu_read_data,
    input  logic                           data_bus_direction,
    input  logic                           timer_out1,
    input  logic [3:0]                     dma_request,
    input  logic [3:0]                     dma_acknowledge_n,
    input  logic [3:0]                     dma_request_out,
    output int unsigned                    error_count
);

    logic       in_cycle;
    int         position;
    logic       model_prev_timer;
    logic       model_pending;
    logic [3:0] expected_request;

    initial error_count = 0;

    task automatic log_error(input string message);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, message);
    endtask

    // Refresh request model with the acknowledge clearing ahead of a new edge
    always @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            model_prev_timer <= 1'b1;
            model_pending    <= 1'b0;
        end
        else
        begin
            model_prev_timer <= timer_out1;
            if (!dma_acknowledge_n[0])
                model_pending <= 1'b0;
            else if (!model_prev_timer && timer_out1)
                model_pending <= 1'b1;
        end
    end

    // Sampled mid-period between the edges
    always @(negedge clock)
    begin
        if (reset)
        begin
            in_cycle = 1'b0;
            position = 0;
        end
        else
        begin
            if (address_latch_enable)
            begin
                if (!expect_cycle || in_cycle)
                    log_error("address latch pulse without a started bus cycle");
                if (command !== '1 || processor_ready)
                    log_error($sformatf("t1 shows command %b ready %b", command,
                                        processor_ready));
                in_cycle = 1'b1;
                position = 0;
            end
            else if (in_cycle)
            begin
                position++;
                if (address !== expected_address)
                    log_error($sformatf("address %h, expected %h", address, expected_address));
                if (select !== expected_select)
                    log_error($sformatf("select %b, expected %b", select, expected_select));
                if (position < expected_length)
                begin
                    if (command !== expected_command)
                        log_error($sformatf("command %b, expected %b", command,
                                            expected_command));
                    if (data_bus_direction !== expected_direction)
                        log_error($sformatf("direction %b, expected %b", data_bus_direction,
                                            expected_direction));
                    if (processor_ready)
                        log_error($sformatf("processor_ready early, %0d cycles after t1",
                                            position));
                end
                else
                begin
                    if (processor_ready !== 1'b1)
                        log_error($sformatf("processor_ready missing %0d cycles after t1",
                                            position));
                    if (command !== '1 || data_bus_direction)
                        log_error("command or direction still active in t4");
                    if (cpu_read_data !== expected_read_data)
                        log_error($sformatf("cpu_read_data %h, expected %h", cpu_read_data,
                                            expected_read_data));
                    in_cycle = 1'b0;
                end
            end
            else if (command !== '1 || processor_ready || data_bus_direction)
                log_error($sformatf("idle bus shows command %b ready %b direction %b",
                                    command, processor_ready, data_bus_direction));

            expected_request = {dma_request[3:1], model_pending};
            if (dma_request_out !== expected_request)
                log_error($sformatf("dma_request_out %b, expected %b", dma_request_out,
                                    expected_request));
        end
    end

endmodule

// ==== verification/xt_chipset_tb.sv ====
//////////////////////////////
// Testbench: clock, reset, bus
// cycle stimulus, reference model
//////////////////////////////
`timescale 1ns/1ns
`include "xt_chipset_macros.svh"

module xt_chipset_tb;

    // Bus cycles issued by the stimulus below
    localparam int cycles_issued = 47;
    localparam int timeout_limit = 300 * cycles_issued + 100;

    typedef struct packed
    {
        xt_chipset_pkg::bus_command_t   command;
        xt_chipset_pkg::device_select_t select;
        logic [`XT_DATA_WIDTH-1:0]      data;
        logic                           direction;
        logic                           is_read;
        logic [7:0]                     length;
    } expected_t;

    logic                           clock;
    logic                           reset;
    logic [`XT_ADDR_WIDTH-1:0]      cpu_address;
    xt_chipset_pkg::bus_status_e    processor_status;
    logic                           io_channel_ready;
    logic                           timer_out1;
    logic [3:0]                     dma_request;
    logic [3:0]                     dma_acknowledge_n;
    logic [`XT_DATA_WIDTH-1:0]      device_read_data;
    logic [`XT_DATA_WIDTH-1:0]      data_bus_ext;
    logic [`XT_ADDR_WIDTH-1:0]      address;
    logic                           address_latch_enable;
    xt_chipset_pkg::bus_command_t   command;
    xt_chipset_pkg::device_select_t select;
    logic                           processor_ready;
    logic [`XT_DATA_WIDTH-1:0]      cpu_read_data;
    logic                           data_bus_direction;
    logic [3:0]                     dma_request_out;

    logic                           expect_cycle;
    expected_t                      expected;
    logic [`XT_DATA_WIDTH-1:0]      expected_read_data;
    int unsigned                    error_count;
    int                             cycle_count;

    xt_chipset_pkg::bus_status_e starting_codes [6] = '{
        xt_chipset_pkg::int_ack, xt_chipset_pkg::io_read, xt_chipset_pkg::io_write,
        xt_chipset_pkg::code_fetch, xt_chipset_pkg::mem_read, xt_chipset_pkg::mem_write};

    xt_chipset i_xt_chipset (.*);

    xt_chipset_checker i_xt_chipset_checker (
        .expect_cycle       (expect_cycle),
        .expected_command   (expected.command),
        .expected_select    (expected.select),
        .expected_address   (cpu_address),
        .expected_direction (expected.direction),
        .expected_length    (expected.length),
        .expected_read_data (expected_read_data),
        .*
    );

    always #2 clock = ~clock;

    function automatic logic in_block(input logic [9:0] port, input logic [9:0] base);
        return (port >= base) && (port < base + 10'd32);
    endfunction

    function automatic expected_t predict_cycle(
        input xt_chipset_pkg::bus_status_e status,
        input logic [`XT_ADDR_WIDTH-1:0]   addr,
        input logic [`XT_DATA_WIDTH-1:0]   device_data,
        input logic [`XT_DATA_WIDTH-1:0]   ext_data,
        input int                          stalls
    );
        expected_t result;
        logic      is_io;
        result         = '0;
        result.command = '1;
        is_io = (status == xt_chipset_pkg::io_read) || (status == xt_chipset_pkg::io_write);
        case (status)
            xt_chipset_pkg::int_ack:    result.command.interrupt_acknowledge_n = 1'b0;
            xt_chipset_pkg::io_read:    result.command.io_read_n = 1'b0;
            xt_chipset_pkg::io_write:   result.command.io_write_n = 1'b0;
            xt_chipset_pkg::mem_write:  result.command.memory_write_n = 1'b0;
            default:                    result.command.memory_read_n = 1'b0;
        endcase
        if (is_io && addr[19:10] == 10'h000)
        begin
            result.select.dma  = in_block(addr[9:0], `XT_PORT_DMA);
            result.select.pic  = in_block(addr[9:0], `XT_PORT_PIC);
            result.select.pit  = in_block(addr[9:0], `XT_PORT_PIT);
            result.select.ppi  = in_block(addr[9:0], `XT_PORT_PPI);
            result.select.page = in_block(addr[9:0], `XT_PORT_PAGE);
        end
        result.is_read = (status != xt_chipset_pkg::io_write) &&
                         (status != xt_chipset_pkg::mem_write);
        // On-board device answers an I/O read and the channel every other read
        if (status == xt_chipset_pkg::io_read && (|result.select))
            result.data = device_data;
        else if (result.is_read)
        begin
            result.data      = ext_data;
            result.direction = 1'b1;
        end
        result.length = 8'(3 + stalls + ((is_io || status == xt_chipset_pkg::int_ack) ?
                                         `XT_IO_WAIT_STATES : 0));
        return result;
    endfunction

    task automatic run_bus_cycle(input xt_chipset_pkg::bus_status_e status,
                                 input logic [`XT_ADDR_WIDTH-1:0] addr, input int stalls);
        logic [`XT_DATA_WIDTH-1:0] device_data;
        logic [`XT_DATA_WIDTH-1:0] ext_data;
        device_data = `XT_DATA_WIDTH'($urandom);
        ext_data    = `XT_DATA_WIDTH'($urandom);
        @(posedge clock);
        #1;
        processor_status = status;
        cpu_address      = addr;
        device_read_data = device_data;
        data_bus_ext     = ext_data;
        expect_cycle     = 1'b1;
        expected         = predict_cycle(status, addr, device_data, ext_data, stalls);
        if (expected.is_read)
            expected_read_data = expected.data;
        // t3 starts on the third edge after the status is driven
        repeat (3) @(posedge clock);
        if (stalls > 0)
        begin
            #1;
            io_channel_ready = 1'b0;
            repeat (stalls) @(posedge clock);
            #1;
            io_channel_ready = 1'b1;
        end
        do
            @(negedge clock);
        while (processor_ready !== 1'b1);
        @(posedge clock);
        #1;
        processor_status = xt_chipset_pkg::passive;
        expect_cycle     = 1'b0;
    endtask

    task automatic hold_status(input xt_chipset_pkg::bus_status_e status, input int cycles);
        @(posedge clock);
        #1;
        processor_status = status;
        repeat (cycles) @(posedge clock);
        #1;
        processor_status = xt_chipset_pkg::passive;
    endtask

    task automatic exercise_refresh();
        for (int i = 0; i < 6; i++)
        begin
            @(posedge clock);
            #1;
            timer_out1  = 1'b1;
            dma_request = 4'($urandom);
            // One edge lands together with the acknowledge
            dma_acknowledge_n = (i == 3) ? 4'($urandom) & 4'b1110 : 4'($urandom) | 4'b0001;
            repeat (2) @(posedge clock);
            #1;
            timer_out1        = 1'b0;
            dma_acknowledge_n = 4'($urandom) | 4'b0001;
            repeat ($urandom_range(1, 4)) @(posedge clock);
            #1;
            dma_acknowledge_n[0] = 1'b0;
            dma_request          = 4'($urandom);
            @(posedge clock);
            #1;
            dma_acknowledge_n[0] = 1'b1;
        end
    endtask

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Errors: %0d", error_count);
            $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(32'h03fa_e564));
        clock              = 1'b0;
        reset              = 1'b1;
        cpu_address        = '0;
        processor_status   = xt_chipset_pkg::passive;
        io_channel_ready   = 1'b1;
        timer_out1         = 1'b0;
        dma_request        = '0;
        dma_acknowledge_n  = '1;
        device_read_data   = '0;
        data_bus_ext       = '0;
        expect_cycle       = 1'b0;
        expected           = '0;
        expected_read_data = '0;
        cycle_count        = 0;
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        foreach (starting_codes[i])
            repeat (4)
                run_bus_cycle(starting_codes[i], `XT_ADDR_WIDTH'($urandom), 0);
        hold_status(xt_chipset_pkg::halt, 8);
        hold_status(xt_chipset_pkg::passive, 4);

        // Block bases, a gap port, ports above 3FFh, then random on-board ports
        run_bus_cycle(xt_chipset_pkg::io_read,  {10'h000, `XT_PORT_DMA}, 0);
        run_bus_cycle(xt_chipset_pkg::io_write, {10'h000, `XT_PORT_PIC}, 0);
        run_bus_cycle(xt_chipset_pkg::io_read,  {10'h000, `XT_PORT_PIT}, 0);
        run_bus_cycle(xt_chipset_pkg::io_write, {10'h000, `XT_PORT_PPI}, 0);
        run_bus_cycle(xt_chipset_pkg::io_read,  {10'h000, `XT_PORT_PAGE}, 0);
        run_bus_cycle(xt_chipset_pkg::io_read,  20'h003f8, 0);
        run_bus_cycle(xt_chipset_pkg::io_read,  20'h00440, 0);
        run_bus_cycle(xt_chipset_pkg::io_write, 20'h00c20, 0);
        run_bus_cycle(xt_chipset_pkg::io_read,  20'hf0060, 0);
        repeat (6)
            run_bus_cycle(starting_codes[$urandom_range(1, 2)],
                          {10'h000, 10'($urandom_range(0, 10'h0bf))}, 0);

        repeat (8)
            run_bus_cycle(starting_codes[$urandom_range(0, 5)], `XT_ADDR_WIDTH'($urandom),
                          $urandom_range(1, 6));

        exercise_refresh();

        repeat (3) @(posedge clock);
        $display("Errors: %0d", error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/xt_chipset_pkg.sv
logic/bus_cycle_control.sv
logic/io_port_decode.sv
logic/refresh_request.sv
logic/data_bus_steer.sv
logic/xt_chipset.sv
verification/xt_chipset_checker.sv
verification/xt_chipset_tb.sv

// ==== Bender.yml ====
package:
  name: xt_chipset

sources:
  - include_dirs:
      - logic
    files:
      - logic/xt_chipset_pkg.sv
      - logic/bus_cycle_control.sv
      - logic/io_port_decode.sv
      - logic/refresh_request.sv
      - logic/data_bus_steer.sv
      - logic/xt_chipset.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/xt_chipset_checker.sv
      - verification/xt_chipset_tb.sv
